//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module exu_tb -f compile.f -o Vexu_tb
	./obj_dir/Vexu_tb | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

//--- compile.f
source/exu_pkg.sv
source/wb_pkg.sv
source/int_alu.sv
source/muldiv_unit.sv
source/exu_bus_regs.sv
source/exu_top.sv
tests/exu_checker.sv
tests/exu_tb.sv

//--- source/exu_bus_regs.sv
module exu_bus_regs (
    input  logic                         clk,
    input  logic                         reset,
    input  wb_pkg::wb_req_t              wb_in,
    output wb_pkg::wb_rsp_t              wb_out,
    output exu_pkg::exu_req_t            req,
    output logic                         start,
    input  logic [exu_pkg::xlen-1:0]     alu_y,
    input  exu_pkg::md_resp_t            md_resp,
    output logic [exu_pkg::xlen-1:0]     hi,
    output logic [exu_pkg::xlen-1:0]     lo
);

    localparam int xlen = exu_pkg::xlen;

    logic [xlen-1:0]   opa_q;
    logic [xlen-1:0]   opb_q;
    logic [xlen-1:0]   ctrl_q;    // Last accepted control word
    logic [xlen-1:0]   result_q;
    logic [xlen-1:0]   hi_q;
    logic [xlen-1:0]   lo_q;
    logic              busy_q;
    logic              zero_q;
    logic              ack_q;
    logic [xlen-1:0]   dat_q;

    logic              access;
    logic              ctrl_wr;
    logic              accept;
    logic              launch;
    logic              launch_md;
    exu_pkg::alu_op_t  new_op;
    logic [4:0]        new_shamt;
    logic [xlen-1:0]   ctrl_word;
    logic [xlen-1:0]   rd_data;

    // Byte-lane write merge
    function automatic logic [xlen-1:0] merge_bytes(input logic [xlen-1:0] cur,
                                                    input logic [xlen-1:0] wdat,
                                                    input logic [3:0]      sel);
        logic [xlen-1:0] res;
        res = cur;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) res[8*i +: 8] = wdat[8*i +: 8];
        end
        return res;
    endfunction

    assign access    = wb_in.cyc && wb_in.stb && !ack_q;  // New cycle, not yet acked
    assign ctrl_wr   = access && wb_in.we && (wb_in.adr == wb_pkg::reg_ctrl);
    assign accept    = access && !(ctrl_wr && busy_q);   // Stall ctrl writes while busy
    assign launch    = ctrl_wr && !busy_q;
    assign new_op    = exu_pkg::alu_op_t'(wb_in.dat[wb_pkg::ctrl_op_msb:wb_pkg::ctrl_op_lsb]);
    assign new_shamt = wb_in.dat[wb_pkg::ctrl_shamt_msb:wb_pkg::ctrl_shamt_lsb];
    assign launch_md = launch && exu_pkg::is_muldiv(new_op);

    always_comb begin
        ctrl_word = '0;
        ctrl_word[wb_pkg::ctrl_op_msb:wb_pkg::ctrl_op_lsb]       = new_op;
        ctrl_word[wb_pkg::ctrl_shamt_msb:wb_pkg::ctrl_shamt_lsb] = new_shamt;
    end

    always_comb begin
        rd_data = '0;
        case (wb_in.adr)
            wb_pkg::reg_opa:    rd_data = opa_q;
            wb_pkg::reg_opb:    rd_data = opb_q;
            wb_pkg::reg_ctrl:   rd_data = ctrl_q;
            wb_pkg::reg_result: rd_data = result_q;
            wb_pkg::reg_hi:     rd_data = hi_q;
            wb_pkg::reg_lo:     rd_data = lo_q;
            wb_pkg::reg_status: begin
                rd_data[wb_pkg::status_busy] = busy_q;
                rd_data[wb_pkg::status_zero] = zero_q;
            end
            default:            rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            ack_q    <= 1'b0;
            dat_q    <= '0;
            opa_q    <= '0;
            opb_q    <= '0;
            ctrl_q   <= '0;
            result_q <= '0;
            hi_q     <= '0;
            lo_q     <= '0;
            busy_q   <= 1'b0;
            zero_q   <= 1'b0;
        end else begin
            ack_q <= accept;
            if (accept && !wb_in.we) dat_q <= rd_data;
            if (accept && wb_in.we) begin
                case (wb_in.adr)
                    wb_pkg::reg_opa:  opa_q  <= merge_bytes(opa_q, wb_in.dat, wb_in.sel);
                    wb_pkg::reg_opb:  opb_q  <= merge_bytes(opb_q, wb_in.dat, wb_in.sel);
                    wb_pkg::reg_ctrl: ctrl_q <= ctrl_word;
                    default: ;  // Read-only, write dropped
                endcase
            end
            // Single-cycle ops land with the ack
            if (launch && !launch_md) begin
                result_q <= alu_y;
                zero_q   <= (alu_y == '0);
            end
            if (launch_md) begin
                busy_q <= 1'b1;
            end else if (md_resp.done) begin
                busy_q <= 1'b0;
                hi_q   <= md_resp.hi;
                lo_q   <= md_resp.lo;
            end
        end
    end

    assign req    = '{op: new_op, a: opa_q, b: opb_q, shamt: new_shamt};
    assign start  = launch_md;
    assign hi     = hi_q;
    assign lo     = lo_q;
    assign wb_out = '{ack: ack_q, dat: dat_q};

endmodule

//--- source/exu_pkg.sv
package exu_pkg;

    localparam int xlen = 32;  // Datapath width

    typedef enum logic [4:0] {
        op_and   = 5'd0,
        op_or    = 5'd1,
        op_xor   = 5'd2,
        op_addu  = 5'd3,
        op_subu  = 5'd4,
        op_sltu  = 5'd5,
        op_slt   = 5'd6,
        op_multu = 5'd7,
        op_mult  = 5'd8,
        op_sll   = 5'd9,
        op_sllv  = 5'd10,
        op_sra   = 5'd11,
        op_srl   = 5'd12,
        op_srav  = 5'd13,
        op_srlv  = 5'd14,
        op_div   = 5'd15,
        op_divu  = 5'd16,
        op_mfhi  = 5'd17,
        op_mflo  = 5'd18,
        op_bltz  = 5'd19,
        op_bgtz  = 5'd20,
        op_bgez  = 5'd21,
        op_bne   = 5'd22,
        op_blez  = 5'd23,
        op_jr    = 5'd24
    } alu_op_t;

    typedef struct packed {
        alu_op_t         op;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [4:0]      shamt;
    } exu_req_t;

    typedef struct packed {
        logic [xlen-1:0] hi;
        logic [xlen-1:0] lo;
        logic            done;  // One-cycle completion pulse
    } md_resp_t;

    // Ops that go to the iterative unit
    function automatic logic is_muldiv(input alu_op_t op);
        return (op == op_multu) || (op == op_mult) || (op == op_div) || (op == op_divu);
    endfunction

endpackage

//--- source/exu_top.sv
module exu_top #(
    parameter int mul_step_bits = 2  // Multiplier bits per cycle
) (
    input  logic            clk,
    input  logic            reset,
    input  wb_pkg::wb_req_t wb_in,
    output wb_pkg::wb_rsp_t wb_out
);

    exu_pkg::exu_req_t            req;
    exu_pkg::md_resp_t            md_resp;
    logic                         start;
    logic [exu_pkg::xlen-1:0]     alu_y;
    logic [exu_pkg::xlen-1:0]     hi;
    logic [exu_pkg::xlen-1:0]     lo;

    exu_bus_regs exu_bus_regs_inst (
        .clk     (clk),
        .reset   (reset),
        .wb_in   (wb_in),
        .wb_out  (wb_out),
        .req     (req),
        .start   (start),
        .alu_y   (alu_y),
        .md_resp (md_resp),
        .hi      (hi),
        .lo      (lo)
    );

    int_alu int_alu_inst (
        .req (req),
        .hi  (hi),
        .lo  (lo),
        .y   (alu_y)
    );

    muldiv_unit #(
        .mul_step_bits (mul_step_bits)
    ) muldiv_unit_inst (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .req   (req),
        .resp  (md_resp)
    );

endmodule

//--- source/int_alu.sv
module int_alu (
    input  exu_pkg::exu_req_t            req,
    input  logic [exu_pkg::xlen-1:0]     hi,
    input  logic [exu_pkg::xlen-1:0]     lo,
    output logic [exu_pkg::xlen-1:0]     y
);

    logic [4:0] var_amt;       // Variable shift amount
    logic       a_neg;
    logic       a_is_zero;
    logic       slt_signed;
    logic       slt_unsigned;
    logic       cond_taken;    // Branch compare result
    logic       is_branch;

    assign var_amt      = req.a[4:0];
    assign a_neg        = req.a[exu_pkg::xlen-1];
    assign a_is_zero    = (req.a == '0);
    assign slt_signed   = $signed(req.a) < $signed(req.b);
    assign slt_unsigned = req.a < req.b;

    // Branch conditions, evaluated once and shared
    always_comb begin
        is_branch  = 1'b1;
        cond_taken = 1'b0;
        case (req.op)
            exu_pkg::op_bltz: cond_taken = a_neg;
            exu_pkg::op_bgtz: cond_taken = !a_neg && !a_is_zero;
            exu_pkg::op_bgez: cond_taken = !a_neg;
            exu_pkg::op_bne:  cond_taken = (req.a != req.b);
            exu_pkg::op_blez: cond_taken = a_neg || a_is_zero;
            default:          is_branch  = 1'b0;
        endcase
    end

    always_comb begin
        y = '0;  // Unknown and mul/div ops
        case (req.op)
            exu_pkg::op_and:  y = req.a & req.b;
            exu_pkg::op_or:   y = req.a | req.b;
            exu_pkg::op_xor:  y = req.a ^ req.b;
            exu_pkg::op_addu: y = req.a + req.b;
            exu_pkg::op_subu: y = req.a - req.b;
            exu_pkg::op_sltu: y = {{(exu_pkg::xlen-1){1'b0}}, slt_unsigned};
            exu_pkg::op_slt:  y = {{(exu_pkg::xlen-1){1'b0}}, slt_signed};

            // Fixed amount from the control word
            exu_pkg::op_sll:  y = req.b << req.shamt;
            exu_pkg::op_srl:  y = req.b >> req.shamt;
            exu_pkg::op_sra:  y = $unsigned($signed(req.b) >>> req.shamt);

            // Amount from low bits of a
            exu_pkg::op_sllv: y = req.b << var_amt;
            exu_pkg::op_srlv: y = req.b >> var_amt;
            exu_pkg::op_srav: y = $unsigned($signed(req.b) >>> var_amt);

            exu_pkg::op_mfhi: y = hi;
            exu_pkg::op_mflo: y = lo;
            exu_pkg::op_jr:   y = req.a;  // Target passes straight through

            default: begin
                if (is_branch) begin
                    // Zero result means taken
                    y = {{(exu_pkg::xlen-1){1'b0}}, !cond_taken};
                end
            end
        endcase
    end

endmodule

//--- source/muldiv_unit.sv
module muldiv_unit #(
    parameter int mul_step_bits = 2
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  exu_pkg::exu_req_t req,
    output exu_pkg::md_resp_t resp
);

    localparam int xlen      = exu_pkg::xlen;
    localparam int mul_iters = xlen / mul_step_bits;

    logic                          run_q;
    logic                          fin_q;
    logic                          done_q;
    logic [5:0]                    count_q;
    logic                          is_div_q;
    logic                          neg_q;      // Product or quotient sign
    logic                          neg_rem_q;  // Dividend sign
    logic                          dz_q;       // Divide by zero
    logic [xlen-1:0]               opnd_q;     // Multiplicand or divisor
    logic [xlen-1:0]               acc_hi_q;   // Upper product or remainder
    logic [xlen-1:0]               acc_lo_q;   // Multiplier bits or quotient
    logic [xlen-1:0]               res_hi_q;
    logic [xlen-1:0]               res_lo_q;

    logic                          req_div;
    logic                          req_signed;
    logic                          sign_a;
    logic                          sign_b;
    logic [xlen-1:0]               mag_a;
    logic [xlen-1:0]               mag_b;
    logic [mul_step_bits-1:0]      digit;
    logic [xlen+mul_step_bits-1:0] mul_sum;
    logic [xlen:0]                 div_shift;
    logic [xlen:0]                 div_diff;
    logic                          div_ge;
    logic [2*xlen-1:0]             prod_fix;
    logic [xlen-1:0]               fix_hi;
    logic [xlen-1:0]               fix_lo;

    always_comb begin
        req_div    = (req.op == exu_pkg::op_div) || (req.op == exu_pkg::op_divu);
        req_signed = (req.op == exu_pkg::op_div) || (req.op == exu_pkg::op_mult);
        sign_a     = req_signed && req.a[xlen-1];
        sign_b     = req_signed && req.b[xlen-1];
        mag_a      = sign_a ? -req.a : req.a;
        mag_b      = sign_b ? -req.b : req.b;

        // Shift-add step on the low multiplier digit
        digit   = acc_lo_q[mul_step_bits-1:0];
        mul_sum = acc_hi_q + opnd_q * digit;

        // Restoring divide step
        div_shift = {acc_hi_q, acc_lo_q[xlen-1]};
        div_diff  = div_shift - {1'b0, opnd_q};
        div_ge    = div_shift >= {1'b0, opnd_q};

        prod_fix = neg_q ? -{acc_hi_q, acc_lo_q} : {acc_hi_q, acc_lo_q};
        if (is_div_q) begin
            fix_hi = neg_rem_q ? -acc_hi_q : acc_hi_q;
            fix_lo = dz_q ? '1 : (neg_q ? -acc_lo_q : acc_lo_q);
        end else begin
            fix_hi = prod_fix[2*xlen-1:xlen];
            fix_lo = prod_fix[xlen-1:0];
        end
    end

    // Sequencing
    always_ff @(posedge clk) begin
        if (!reset) begin
            run_q   <= 1'b0;
            fin_q   <= 1'b0;
            done_q  <= 1'b0;
            count_q <= '0;
        end else begin
            done_q <= fin_q;
            fin_q  <= 1'b0;
            if (start) begin
                run_q   <= 1'b1;
                count_q <= req_div ? 6'(xlen - 1) : 6'(mul_iters - 1);
            end else if (run_q) begin
                if (count_q == '0) begin
                    run_q <= 1'b0;
                    fin_q <= 1'b1;  // Sign fixup next
                end else begin
                    count_q <= count_q - 6'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            is_div_q  <= req_div;
            neg_q     <= sign_a ^ sign_b;
            neg_rem_q <= sign_a;
            dz_q      <= (req.b == '0);
            opnd_q    <= req_div ? mag_b : mag_a;
            acc_lo_q  <= req_div ? mag_a : mag_b;
            acc_hi_q  <= '0;
        end else if (run_q) begin
            if (is_div_q) begin
                acc_hi_q <= div_ge ? div_diff[xlen-1:0] : div_shift[xlen-1:0];
                acc_lo_q <= {acc_lo_q[xlen-2:0], div_ge};
            end else begin
                {acc_hi_q, acc_lo_q} <= {mul_sum, acc_lo_q[xlen-1:mul_step_bits]};
            end
        end
        if (fin_q) begin
            res_hi_q <= fix_hi;
            res_lo_q <= fix_lo;
        end
    end

    assign resp = '{hi: res_hi_q, lo: res_lo_q, done: done_q};

endmodule

//--- source/wb_pkg.sv
package wb_pkg;

    localparam int wb_dw = 32;  // Bus data width

    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [2:0]       adr;  // Word address
        logic [wb_dw-1:0] dat;
        logic [3:0]       sel;
    } wb_req_t;

    typedef struct packed {
        logic             ack;
        logic [wb_dw-1:0] dat;
    } wb_rsp_t;

    // Register map
    localparam logic [2:0] reg_opa    = 3'd0;
    localparam logic [2:0] reg_opb    = 3'd1;
    localparam logic [2:0] reg_ctrl   = 3'd2;
    localparam logic [2:0] reg_result = 3'd3;
    localparam logic [2:0] reg_hi     = 3'd4;
    localparam logic [2:0] reg_lo     = 3'd5;
    localparam logic [2:0] reg_status = 3'd6;

    // Control word fields
    localparam int ctrl_op_lsb    = 0;
    localparam int ctrl_op_msb    = 4;
    localparam int ctrl_shamt_lsb = 8;
    localparam int ctrl_shamt_msb = 12;

    // Status word bits
    localparam int status_busy = 0;
    localparam int status_zero = 1;

endpackage

//--- tests/exu_checker.sv
module exu_checker #(
    parameter int mul_step_bits = 2
) (
    input  logic            clk,
    input  logic            reset,
    input  wb_pkg::wb_req_t wb_in,
    input  wb_pkg::wb_rsp_t wb_out,
    input  logic [8*16-1:0] test_name,
    output int              error_count,
    output int              check_count
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int xlen     = exu_pkg::xlen;
    localparam int mul_busy = xlen / mul_step_bits + 2;  // Latency plus the edge that clears busy
    localparam int div_busy = 34;

    typedef struct packed {
        logic [xlen-1:0] result;
        logic [xlen-1:0] hi;
        logic [xlen-1:0] lo;
        logic            zero;
        logic            md;  // Last op ran on the iterative unit
    } model_t;

    model_t          st;
    logic [xlen-1:0] opa;
    logic [xlen-1:0] opb;
    logic [xlen-1:0] ctrl;
    logic [xlen-1:0] exp_status;
    wb_pkg::wb_req_t prev_req;  // Request as seen on the accepting edge
    logic            md_pend;
    int              md_age;
    int              md_busy;   // Accepting edges that still see busy
    logic            busy_exp;

    function automatic model_t exu_model(input logic [4:0] op, input logic [xlen-1:0] a,
                                         input logic [xlen-1:0] b, input logic [4:0] shamt,
                                         input model_t prev);
        model_t             nxt;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0]        wide;
        nxt    = prev;
        nxt.md = 1'b0;
        sa     = $signed(a);
        sb     = $signed(b);
        wide   = '0;
        case (op)
            exu_pkg::op_and:  nxt.result = a & b;
            exu_pkg::op_or:   nxt.result = a | b;
            exu_pkg::op_xor:  nxt.result = a ^ b;
            exu_pkg::op_addu: nxt.result = a + b;
            exu_pkg::op_subu: nxt.result = a - b;
            exu_pkg::op_sltu: nxt.result = (a < b) ? 32'd1 : 32'd0;
            exu_pkg::op_slt:  nxt.result = (sa < sb) ? 32'd1 : 32'd0;
            exu_pkg::op_sll:  nxt.result = b << shamt;
            exu_pkg::op_srl:  nxt.result = b >> shamt;
            exu_pkg::op_sllv: nxt.result = b << a[4:0];
            exu_pkg::op_srlv: nxt.result = b >> a[4:0];
            exu_pkg::op_sra: begin
                wide       = sb >> shamt;  // Sign copies move into the low word
                nxt.result = wide[xlen-1:0];
            end
            exu_pkg::op_srav: begin
                wide       = sb >> a[4:0];
                nxt.result = wide[xlen-1:0];
            end
            exu_pkg::op_multu: begin
                wide             = {32'd0, a} * {32'd0, b};
                {nxt.hi, nxt.lo} = wide;
                nxt.md           = 1'b1;
            end
            exu_pkg::op_mult: begin
                wide             = sa * sb;
                {nxt.hi, nxt.lo} = wide;
                nxt.md           = 1'b1;
            end
            exu_pkg::op_div, exu_pkg::op_divu: begin
                nxt.md = 1'b1;
                if (b == '0) begin
                    nxt.hi = a;
                    nxt.lo = '1;
                end else if (op == exu_pkg::op_divu) begin
                    nxt.lo = a / b;
                    nxt.hi = a % b;
                end else begin
                    wide   = sa / sb;  // Truncates toward zero
                    nxt.lo = wide[xlen-1:0];
                    wide   = sa % sb;
                    nxt.hi = wide[xlen-1:0];
                end
            end
            exu_pkg::op_mfhi: nxt.result = prev.hi;
            exu_pkg::op_mflo: nxt.result = prev.lo;
            exu_pkg::op_bltz: nxt.result = (sa < 0) ? 32'd0 : 32'd1;
            exu_pkg::op_bgtz: nxt.result = (sa > 0) ? 32'd0 : 32'd1;
            exu_pkg::op_bgez: nxt.result = (sa >= 0) ? 32'd0 : 32'd1;
            exu_pkg::op_bne:  nxt.result = (a != b) ? 32'd0 : 32'd1;
            exu_pkg::op_blez: nxt.result = (sa <= 0) ? 32'd0 : 32'd1;
            exu_pkg::op_jr:   nxt.result = a;
            default:          nxt.result = '0;
        endcase
        if (!nxt.md) begin
            nxt.zero = (nxt.result == '0);
        end
        return nxt;
    endfunction

    task automatic compare(input string what, input logic [xlen-1:0] exp,
                           input logic [xlen-1:0] act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("ERROR %0s: %0s expected 0x%08h actual 0x%08h", test_name, what, exp, act);
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            st          = '0;
            opa         = '0;
            opb         = '0;
            ctrl        = '0;
            prev_req    = '0;
            md_pend     = 1'b0;
            md_age      = 0;
            md_busy     = 0;
            busy_exp    = 1'b0;
            error_count = 0;
            check_count = 0;
        end else begin
            if (md_pend) begin
                md_age++;
            end
            busy_exp = md_pend && (md_age <= md_busy);
            if (wb_out.ack && prev_req.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (prev_req.sel[i] && prev_req.adr == wb_pkg::reg_opa) begin
                        opa[8*i +: 8] = prev_req.dat[8*i +: 8];
                    end
                    if (prev_req.sel[i] && prev_req.adr == wb_pkg::reg_opb) begin
                        opb[8*i +: 8] = prev_req.dat[8*i +: 8];
                    end
                end
                if (prev_req.adr == wb_pkg::reg_ctrl) begin
                    if (busy_exp) begin
                        error_count++;
                        $display("Test %0s: control write accepted while busy", test_name);
                    end
                    ctrl    = {19'd0, prev_req.dat[12:8], 3'd0, prev_req.dat[4:0]};
                    st      = exu_model(prev_req.dat[4:0], opa, opb, prev_req.dat[12:8], st);
                    md_pend = st.md;
                    md_busy = (prev_req.dat[4:0] == exu_pkg::op_div ||
                               prev_req.dat[4:0] == exu_pkg::op_divu) ? div_busy : mul_busy;
                    md_age  = 0;
                end
            end else if (wb_out.ack) begin
                case (prev_req.adr)
                    wb_pkg::reg_opa:    compare("opa", opa, wb_out.dat);
                    wb_pkg::reg_opb:    compare("opb", opb, wb_out.dat);
                    wb_pkg::reg_ctrl:   compare("ctrl", ctrl, wb_out.dat);
                    wb_pkg::reg_result: compare("result", st.result, wb_out.dat);
                    wb_pkg::reg_hi:     compare("hi", st.hi, wb_out.dat);
                    wb_pkg::reg_lo:     compare("lo", st.lo, wb_out.dat);
                    wb_pkg::reg_status: begin
                        exp_status = {30'd0, st.zero, busy_exp};
                        compare("status", exp_status, wb_out.dat);
                    end
                    default:            compare("unmapped", '0, wb_out.dat);
                endcase
            end else if (prev_req.cyc && prev_req.stb) begin
                // Only a control write may wait, and only while busy
                if (!(prev_req.we && prev_req.adr == wb_pkg::reg_ctrl && busy_exp)) begin
                    error_count++;
                    $display("Test %0s: no ack one cycle after a request to register %0d",
                             test_name, prev_req.adr);
                end
            end
            prev_req = wb_in;
        end
    end

endmodule

//--- tests/exu_tb.sv
module exu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int bus_limit     = 100;  // Cycles to wait for ack
    localparam int poll_limit    = 60;   // Status reads before giving up
    localparam int mul_step_bits = 2;

    logic            clk;
    logic            reset;
    wb_pkg::wb_req_t wb_in;
    wb_pkg::wb_rsp_t wb_out;
    logic [8*16-1:0] test_name;
    int              tb_errors;
    int              chk_errors;
    int              chk_count;
    int              seed;
    logic [31:0]     rd;
    logic [31:0]     corner [6];
    logic [31:0]     md_a [4];
    logic [31:0]     md_b [4];

    exu_top #(
        .mul_step_bits (mul_step_bits)
    ) exu_top_inst (
        .clk    (clk),
        .reset  (reset),
        .wb_in  (wb_in),
        .wb_out (wb_out)
    );

    exu_checker #(
        .mul_step_bits (mul_step_bits)
    ) exu_checker_inst (
        .clk         (clk),
        .reset       (reset),
        .wb_in       (wb_in),
        .wb_out      (wb_out),
        .test_name   (test_name),
        .error_count (chk_errors),
        .check_count (chk_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic wait_ack(output logic [31:0] q);
        int n;
        n = 0;
        q = '0;
        while (n < bus_limit) begin
            @(negedge clk);
            if (wb_out.ack) break;
            n++;
        end
        if (n == bus_limit) begin
            tb_errors++;
            $display("Bus cycle to register %0d got no ack in %0d cycles", wb_in.adr, n);
        end else begin
            q = wb_out.dat;
        end
        wb_in.cyc = 1'b0;  // Release on the ack cycle
        wb_in.stb = 1'b0;
        wb_in.we  = 1'b0;
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        @(negedge clk);
        wb_in = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat, sel: 4'hf};
        wait_ack(unused);
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [31:0] q);
        @(negedge clk);
        wb_in = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'd0, sel: 4'hf};
        wait_ack(q);
    endtask

    task automatic wait_idle();
        logic [31:0] s;
        int          n;
        s = 32'd1;
        n = 0;
        while (n < poll_limit && s[0]) begin
            wb_read(wb_pkg::reg_status, s);
            n++;
        end
        if (s[0]) begin
            tb_errors++;
            $display("Busy did not clear after %0d status reads", n);
        end
    endtask

    task automatic launch(input logic [4:0] op, input logic [31:0] a, input logic [31:0] b,
                          input logic [4:0] shamt);
        wb_write(wb_pkg::reg_opa, a);
        wb_write(wb_pkg::reg_opb, b);
        wb_write(wb_pkg::reg_ctrl, {19'd0, shamt, 3'd0, op});
    endtask

    task automatic read_all();
        logic [31:0] q;
        wait_idle();
        wb_read(wb_pkg::reg_result, q);
        wb_read(wb_pkg::reg_hi, q);
        wb_read(wb_pkg::reg_lo, q);
        wb_read(wb_pkg::reg_status, q);
    endtask

    task automatic run_op(input logic [4:0] op, input logic [31:0] a, input logic [31:0] b,
                          input logic [4:0] shamt);
        launch(op, a, b, shamt);
        read_all();
    endtask

    initial begin
        wb_in     = '0;
        reset     = 1'b0;
        tb_errors = 0;
        seed      = 32'hf74;
        test_name = "reset";
        corner    = '{32'h0, 32'h1, 32'hffffffff, 32'h80000000, 32'h7fffffff, 32'h0000fff0};
        md_a      = '{32'd7, 32'hfffffff9, 32'h80000000, 32'h12345678};
        md_b      = '{32'd3, 32'hfffffffd, 32'd0, 32'hffffffff};
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        for (int r = 0; r < 8; r++) begin
            wb_read(3'(r), rd);
        end

        test_name = "alu_basic";
        for (int op = 0; op <= 6; op++) begin
            for (int i = 0; i < 6; i++) begin
                run_op(5'(op), corner[i], corner[5-i], 5'd0);
            end
        end
        for (int i = 0; i < 20; i++) begin
            run_op(5'($unsigned($random(seed)) % 7), $random(seed), $random(seed), 5'd0);
        end

        test_name = "shifts";
        for (int k = 0; k < 2; k++) begin
            for (int j = 0; j < 4; j++) begin
                for (int op = 9; op <= 14; op++) begin
                    // a[4:0] differs from shamt so the two sources stay apart
                    run_op(5'(op), 32'habcdef00 | (31 - ((j == 3) ? 31 : j * 7)),
                           (k == 0) ? 32'h80000001 : 32'h12345678,
                           5'((j == 3) ? 31 : j * 7));
                end
            end
        end

        test_name = "branch_jr";
        for (int op = 19; op <= 24; op++) begin
            for (int i = 0; i < 6; i++) begin
                run_op(5'(op), corner[i], 32'd7, 5'd0);
                run_op(5'(op), corner[i], corner[i], 5'd0);
            end
        end

        test_name = "muldiv";
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    run_op(5'((k < 2) ? 7 + k : 13 + k), md_a[i], md_b[j], 5'd0);
                    run_op(exu_pkg::op_mfhi, 32'd0, 32'd0, 5'd0);
                    run_op(exu_pkg::op_mflo, 32'd0, 32'd0, 5'd0);
                end
            end
        end

        test_name = "stall";
        launch(exu_pkg::op_div, 32'hfffff000, 32'd7, 5'd0);
        launch(exu_pkg::op_mflo, 32'h1111, 32'h2222, 5'd0);  // Control write waits on busy
        read_all();
        launch(exu_pkg::op_mult, 32'hffff0001, 32'h00010003, 5'd0);
        launch(exu_pkg::op_addu, 32'd5, 32'd6, 5'd0);
        read_all();

        test_name = "random_mix";
        for (int i = 0; i < 200; i++) begin
            launch(5'($random(seed)), $random(seed), $random(seed), 5'($random(seed)));
            if ($random(seed) & 1) begin
                wb_read(wb_pkg::reg_result, rd);
                wb_read(wb_pkg::reg_status, rd);
            end else begin
                read_all();
            end
        end
        read_all();

        @(posedge clk);
        @(negedge clk);
        $display("Checks: %0d, checker errors: %0d, bus errors: %0d",
                 chk_count, chk_errors, tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
